// ==== hdl/seq_pkg.sv ====
// ---------------------------------------------------------------------
// Defaults for in-flight sequence number tracking. The top level takes
// these as its parameter defaults and passes them down to the generator.
// ---------------------------------------------------------------------

package seq_pkg;

  // ---------------------------------------------------------------------
  // Sequence number space
  // ---------------------------------------------------------------------

  // Tag width, 2**5 = 32 list entries
  localparam int DEFAULT_SEQ_NUM_BITS = 5;

  // ---------------------------------------------------------------------
  // Reclaim
  // ---------------------------------------------------------------------

  // Max consecutive freed entries the tail can pass per cycle
  // Must stay below 2**DEFAULT_SEQ_NUM_BITS
  localparam int DEFAULT_RECLAIM_WIDTH = 2;

endpackage : seq_pkg

// ==== hdl/fetch_pkg.sv ====
// ---------------------------------------------------------------------
// Fetch-side definitions: PC width and the tagger output buffer state.
// ---------------------------------------------------------------------

package fetch_pkg;

  // Fetch address width
  localparam int PC_BITS = 32;

  // ---------------------------------------------------------------------
  // Tagger output buffer
  // ---------------------------------------------------------------------

  // One-entry buffer, either holding a tagged fetch or not
  typedef enum logic {
    TAG_EMPTY = 1'b0,
    TAG_FULL  = 1'b1
  } tag_state_e;

endpackage : fetch_pkg

// ==== hdl/seq_num_gen.sv ====
// ---------------------------------------------------------------------
// Sequence number allocator. Hands out numbers in order from the head,
// frees them on commit in any order, and reclaims freed numbers at the
// tail in order, up to RECLAIM_WIDTH per cycle.
// ---------------------------------------------------------------------

module seq_num_gen #(
  parameter int SEQ_NUM_BITS  = seq_pkg::DEFAULT_SEQ_NUM_BITS,
  parameter int RECLAIM_WIDTH = seq_pkg::DEFAULT_RECLAIM_WIDTH
) (
  input  logic                    clk,
  input  logic                    rst,

  // Allocation handshake, toward the tagger
  output logic [SEQ_NUM_BITS-1:0] alloc_seq_num,
  output logic                    alloc_val,
  input  logic                    alloc_rdy,

  // Commit notification, no back-pressure
  input  logic                    commit_val,
  input  logic [SEQ_NUM_BITS-1:0] commit_seq_num
);

  import seq_pkg::*;

  localparam int NUM_ENTRIES = 2 ** SEQ_NUM_BITS;

  // One busy bit per number, set on allocate, cleared on commit
  logic [NUM_ENTRIES-1:0]  busy;

  // Head is the next number to hand out, tail the oldest outstanding
  logic [SEQ_NUM_BITS-1:0] head;
  logic [SEQ_NUM_BITS-1:0] tail;
  logic [SEQ_NUM_BITS-1:0] head_next;
  logic                    alloc_fire;

  // Reclaim chain state
  logic [SEQ_NUM_BITS-1:0]  entries_alloc;
  logic [RECLAIM_WIDTH-1:0] reclaim_run;
  logic [SEQ_NUM_BITS-1:0]  tail_incr;

  // ---------------------------------------------------------------------
  // Allocation
  // ---------------------------------------------------------------------

  // Kept at tag width so the compare wraps with the pointers
  assign head_next = head + 1'b1;

  // One slot always left open so full and empty differ
  assign alloc_val     = (head_next != tail);
  assign alloc_seq_num = head;
  assign alloc_fire    = alloc_val && alloc_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      head <= '0;
    end else if (alloc_fire) begin
      head <= head_next;
    end
  end

  // ---------------------------------------------------------------------
  // Busy list
  // ---------------------------------------------------------------------

  // Head entry is never outstanding, so set and clear never collide
  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= '0;
    end else begin
      if (alloc_fire) begin
        busy[head] <= 1'b1;
      end
      if (commit_val) begin
        busy[commit_seq_num] <= 1'b0;
      end
    end
  end

  // ---------------------------------------------------------------------
  // Reclaim
  // ---------------------------------------------------------------------

  // Outstanding count, tail up to but not including head
  assign entries_alloc = head - tail;

  // Prefix chain of free entries starting at the tail
  for (genvar i = 0; i < RECLAIM_WIDTH; i++) begin : g_reclaim
    logic [SEQ_NUM_BITS-1:0] idx;
    logic                    in_range;

    assign idx      = tail + SEQ_NUM_BITS'(i);
    assign in_range = SEQ_NUM_BITS'(i) < entries_alloc;

    if (i == 0) begin : g_first
      assign reclaim_run[i] = !busy[idx] && in_range;
    end else begin : g_chain
      // Stops at the first busy or unallocated entry
      assign reclaim_run[i] = !busy[idx] && in_range && reclaim_run[i-1];
    end
  end

  // Chain length, highest set bit of a prefix run
  always_comb begin
    tail_incr = '0;
    for (int i = 0; i < RECLAIM_WIDTH; i++) begin
      if (reclaim_run[i]) begin
        tail_incr = SEQ_NUM_BITS'(i + 1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      tail <= '0;
    end else begin
      tail <= tail + tail_incr;
    end
  end

  // ---------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------

  // Allocation only lands on an entry already freed and reclaimed
  a_alloc_free: assert property (@(posedge clk) disable iff (rst)
    alloc_fire |-> !busy[head]);

  // Commit stage only frees numbers that are outstanding
  a_commit_busy: assert property (@(posedge clk) disable iff (rst)
    commit_val |-> busy[commit_seq_num]);

  // Empty list leaves no busy entry behind the tail
  a_tail_bound: assert property (@(posedge clk) disable iff (rst)
    (head == tail) |-> (busy == '0));

endmodule : seq_num_gen

// ==== hdl/fetch_tagger.sv ====
// ---------------------------------------------------------------------
// Joins each fetch PC with the next free sequence number and holds the
// pair in a one-entry buffer toward downstream. One cycle of latency,
// full throughput while downstream is ready.
// ---------------------------------------------------------------------

module fetch_tagger #(
  parameter int SEQ_NUM_BITS = seq_pkg::DEFAULT_SEQ_NUM_BITS
) (
  input  logic                         clk,
  input  logic                         rst,

  // Upstream fetch
  input  logic                         fetch_val,
  output logic                         fetch_rdy,
  input  logic [fetch_pkg::PC_BITS-1:0] fetch_pc,

  // Number source
  input  logic                         alloc_val,
  output logic                         alloc_rdy,
  input  logic [SEQ_NUM_BITS-1:0]      alloc_seq_num,

  // Downstream tagged fetch
  output logic                         tag_val,
  input  logic                         tag_rdy,
  output logic [fetch_pkg::PC_BITS-1:0] tag_pc,
  output logic [SEQ_NUM_BITS-1:0]      tag_seq_num
);

  import fetch_pkg::*;

  tag_state_e state;

  // Buffer payload
  logic [PC_BITS-1:0]      pc_q;
  logic [SEQ_NUM_BITS-1:0] seq_q;

  logic room;
  logic load;

  // ---------------------------------------------------------------------
  // Handshake
  // ---------------------------------------------------------------------

  // Empty, or full and draining this cycle
  assign room = (state == TAG_EMPTY) || tag_rdy;

  // alloc_rdy stays independent of alloc_val
  assign alloc_rdy = fetch_val && room;
  assign fetch_rdy = room && alloc_val;

  // Fetch and number taken on the same edge
  assign load = fetch_val && fetch_rdy;

  // ---------------------------------------------------------------------
  // Output buffer
  // ---------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= TAG_EMPTY;
    end else if (load) begin
      state <= TAG_FULL;
    end else if (tag_rdy) begin
      state <= TAG_EMPTY;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      pc_q  <= fetch_pc;
      seq_q <= alloc_seq_num;
    end
  end

  assign tag_val     = (state == TAG_FULL);
  assign tag_pc      = pc_q;
  assign tag_seq_num = seq_q;

  // Stalled output holds its payload
  a_tag_stable: assert property (@(posedge clk) disable iff (rst)
    (tag_val && !tag_rdy) |=> (tag_val && $stable(tag_pc) && $stable(tag_seq_num)));

endmodule : fetch_tagger

// ==== hdl/seq_fetch_top.sv ====
// ---------------------------------------------------------------------
// Fetch tagging front: tagger plus sequence number generator. Sets the
// tag width and reclaim width and passes them to both blocks.
// ---------------------------------------------------------------------

module seq_fetch_top #(
  parameter int SEQ_NUM_BITS  = seq_pkg::DEFAULT_SEQ_NUM_BITS,
  parameter int RECLAIM_WIDTH = seq_pkg::DEFAULT_RECLAIM_WIDTH
) (
  input  logic                          clk,
  input  logic                          rst,

  // Upstream fetch
  input  logic                          fetch_val,
  output logic                          fetch_rdy,
  input  logic [fetch_pkg::PC_BITS-1:0] fetch_pc,

  // Downstream tagged fetch
  output logic                          tag_val,
  input  logic                          tag_rdy,
  output logic [fetch_pkg::PC_BITS-1:0] tag_pc,
  output logic [SEQ_NUM_BITS-1:0]       tag_seq_num,

  // Commit stage frees
  input  logic                          commit_val,
  input  logic [SEQ_NUM_BITS-1:0]       commit_seq_num
);

  import seq_pkg::*;
  import fetch_pkg::*;

  // Tagger to generator handshake
  logic                    alloc_val;
  logic                    alloc_rdy;
  logic [SEQ_NUM_BITS-1:0] alloc_seq_num;

  fetch_tagger #(
    .SEQ_NUM_BITS (SEQ_NUM_BITS)
  ) tagger_i (
    .clk           (clk),
    .rst           (rst),
    .fetch_val     (fetch_val),
    .fetch_rdy     (fetch_rdy),
    .fetch_pc      (fetch_pc),
    .alloc_val     (alloc_val),
    .alloc_rdy     (alloc_rdy),
    .alloc_seq_num (alloc_seq_num),
    .tag_val       (tag_val),
    .tag_rdy       (tag_rdy),
    .tag_pc        (tag_pc),
    .tag_seq_num   (tag_seq_num)
  );

  seq_num_gen #(
    .SEQ_NUM_BITS  (SEQ_NUM_BITS),
    .RECLAIM_WIDTH (RECLAIM_WIDTH)
  ) gen_i (
    .clk            (clk),
    .rst            (rst),
    .alloc_seq_num  (alloc_seq_num),
    .alloc_val      (alloc_val),
    .alloc_rdy      (alloc_rdy),
    .commit_val     (commit_val),
    .commit_seq_num (commit_seq_num)
  );

endmodule : seq_fetch_top

// ==== dv/tb_seq_fetch.sv ====
// ----------------------------------------------------------------------
// Testbench for the fetch tagging front. Drives fetches, downstream
// ready and commits from an LFSR and checks every tag against a model
// of the outstanding sequence numbers.
// ----------------------------------------------------------------------

module tb_seq_fetch;

  import seq_pkg::*;
  import fetch_pkg::*;

  localparam int SN_BITS  = DEFAULT_SEQ_NUM_BITS;
  // One slot always left open in the list
  localparam int CAPACITY = (1 << SN_BITS) - 1;

  logic               clk;
  logic               rst;
  logic               fetch_val;
  logic               fetch_rdy;
  logic [PC_BITS-1:0] fetch_pc;
  logic               tag_val;
  logic               tag_rdy;
  logic [PC_BITS-1:0] tag_pc;
  logic [SN_BITS-1:0] tag_seq_num;
  logic               commit_val;
  logic [SN_BITS-1:0] commit_seq_num;

  // ----------------------------------------------------------------------
  // Model state
  // ----------------------------------------------------------------------

  // Allocated and not yet reclaimed, oldest first
  logic [SN_BITS-1:0] outq[$];
  bit                 freed[2**SN_BITS];
  // Delivered downstream, still uncommitted
  logic [SN_BITS-1:0] live[$];
  // Accepted fetches waiting to show on the tag side
  logic [PC_BITS-1:0] pend_pc[$];
  logic [SN_BITS-1:0] pend_seq[$];
  logic [SN_BITS-1:0] next_seq;

  // What the previous edge saw
  logic               acc_prev;
  logic               stall_prev;
  logic [PC_BITS-1:0] pc_prev;
  logic [SN_BITS-1:0] seq_prev;

  logic [31:0] lfsr;
  logic        timeout_hit;
  int          cycle;
  int          accepts;
  int          checks;
  int          errors;
  int          tests;

  seq_fetch_top dut_i (
    .clk            (clk),
    .rst            (rst),
    .fetch_val      (fetch_val),
    .fetch_rdy      (fetch_rdy),
    .fetch_pc       (fetch_pc),
    .tag_val        (tag_val),
    .tag_rdy        (tag_rdy),
    .tag_pc         (tag_pc),
    .tag_seq_num    (tag_seq_num),
    .commit_val     (commit_val),
    .commit_seq_num (commit_seq_num)
  );

  always #50 clk = ~clk;

  // Timeout ends the run from here
  always @(posedge clk) begin
    if (timeout_hit) begin
      $display("Test FAILED");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  // Galois LFSR, right shift
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
  endfunction

  // n bits, one LFSR step each
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return r;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error cycle %0d: %s got 0x%0h expected 0x%0h", cycle, name, got, exp);
    end
  endtask

  task automatic note_failure(input string what);
    errors++;
    $display("cycle %0d: %s", cycle, what);
  endtask

  // Flag the hang and park this process
  task automatic stall_hit(input string what);
    $display("cycle %0d: timed out waiting for %s", cycle, what);
    timeout_hit = 1'b1;
    forever @(posedge clk);
  endtask

  // Delivered downstream and not yet committed
  function automatic bit is_live(input logic [SN_BITS-1:0] n);
    foreach (live[i]) begin
      if (live[i] == n) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic take_live(input logic [SN_BITS-1:0] n);
    foreach (live[i]) begin
      if (live[i] == n) begin
        live.delete(i);
        return;
      end
    end
  endtask

  // Sampled at the rising edge, before any register moves
  task automatic observe_edge();
    logic [PC_BITS-1:0] exp_pc;
    logic [SN_BITS-1:0] exp_seq;
    cycle++;
    if (acc_prev && !tag_val) begin
      note_failure("tag_val low one cycle after a fetch was accepted");
    end
    if (stall_prev) begin
      if (!tag_val) begin
        note_failure("tag dropped while downstream was stalled");
      end
      compare_value("tag_pc", tag_pc, pc_prev);
      compare_value("tag_seq_num", tag_seq_num, seq_prev);
    end
    // Downstream transfer
    if (tag_val && tag_rdy) begin
      if (pend_pc.size() == 0) begin
        note_failure("tag delivered with no fetch pending");
      end else begin
        exp_pc  = pend_pc.pop_front();
        exp_seq = pend_seq.pop_front();
        compare_value("tag_pc", tag_pc, exp_pc);
        compare_value("tag_seq_num", tag_seq_num, exp_seq);
        if (is_live(tag_seq_num)) begin
          note_failure("tag carries a number that is still outstanding");
        end
        live.push_back(exp_seq);
      end
    end
    stall_prev = tag_val && !tag_rdy;
    pc_prev    = tag_pc;
    seq_prev   = tag_seq_num;
    // Upstream transfer, number taken from the model
    acc_prev = fetch_val && fetch_rdy;
    if (acc_prev) begin
      accepts++;
      if (outq.size() >= CAPACITY) begin
        note_failure("fetch accepted with every number outstanding");
      end
      pend_pc.push_back(fetch_pc);
      pend_seq.push_back(next_seq);
      outq.push_back(next_seq);
      freed[next_seq] = 1'b0;
      next_seq++;
    end
    // Commit frees, reclaim in order
    if (commit_val) begin
      freed[commit_seq_num] = 1'b1;
      while (outq.size() > 0 && freed[outq[0]]) begin
        void'(outq.pop_front());
      end
    end
  endtask

  // One cycle: drive at the falling edge, check at the rising edge
  task automatic drive_cycle(input logic fv, input logic tr, input logic cv,
                             input logic [SN_BITS-1:0] cn);
    @(negedge clk);
    // An offered fetch holds until it transfers
    if (!(fetch_val && !acc_prev)) begin
      fetch_val = fv;
      fetch_pc  = rand_bits(PC_BITS);
    end
    tag_rdy        = tr;
    commit_val     = cv;
    commit_seq_num = cn;
    @(posedge clk);
    observe_edge();
  endtask

  task automatic random_run(input int n, input bit spans);
    int                 span;
    int                 idx;
    logic               tr;
    logic               cv;
    logic [SN_BITS-1:0] cn;
    span = 0;
    tr   = 1'b1;
    for (int c = 0; c < n; c++) begin
      if (!spans) begin
        tr = rand_bits(1) != 0;
      end else if (span == 0) begin
        tr   = rand_bits(1) != 0;
        span = int'(rand_bits(3)) + 1;
      end
      span = (span > 0) ? span - 1 : 0;
      cv = 1'b0;
      cn = '0;
      if (live.size() > 0 && rand_bits(2) == 0) begin
        idx = int'(rand_bits(5)) % live.size();
        cn  = live[idx];
        cv  = 1'b1;
        live.delete(idx);
      end
      drive_cycle(rand_bits(2) != 0, tr, cv, cn);
    end
  endtask

  // Empty the tag side, committing as we go if asked
  task automatic drain_tags(input bit with_commits);
    int                 t;
    logic               cv;
    logic [SN_BITS-1:0] cn;
    t = 0;
    while (pend_pc.size() != 0 || fetch_val) begin
      cv = 1'b0;
      cn = '0;
      if (with_commits && live.size() > 0) begin
        cn = live.pop_front();
        cv = 1'b1;
      end
      drive_cycle(1'b0, 1'b1, cv, cn);
      t++;
      if (t > 200) begin
        stall_hit("the tag side to drain");
      end
    end
  endtask

  task automatic report_test(input string name, input int e0);
    tests++;
    $display("test %-16s finished at cycle %0d, %0d errors", name, cycle, errors - e0);
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------

  initial begin
    int                 a0;
    int                 e0;
    int                 t;
    logic [SN_BITS-1:0] oldest;
    logic [SN_BITS-1:0] second;
    lfsr           = 32'hb7d7126a;
    clk            = 1'b0;
    rst            = 1'b1;
    fetch_val      = 1'b0;
    fetch_pc       = '0;
    tag_rdy        = 1'b0;
    commit_val     = 1'b0;
    commit_seq_num = '0;
    next_seq       = '0;
    acc_prev       = 1'b0;
    stall_prev     = 1'b0;
    timeout_hit    = 1'b0;
    cycle          = 0;
    accepts        = 0;
    checks         = 0;
    errors         = 0;
    tests          = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // In-order numbers from 0, PC carried along
    e0 = errors;
    a0 = accepts;
    t  = 0;
    while (accepts - a0 < 8) begin
      drive_cycle(1'b1, 1'b1, 1'b0, '0);
      t++;
      if (t > 50) begin
        stall_hit("eight fetches after reset");
      end
    end
    drain_tags(1'b0);
    report_test("order_and_pc", e0);

    // Fill the list without commits
    e0 = errors;
    t  = 0;
    while (outq.size() < CAPACITY) begin
      drive_cycle(1'b1, 1'b1, 1'b0, '0);
      t++;
      if (t > 100) begin
        stall_hit("the list to fill");
      end
    end
    repeat (20) begin
      drive_cycle(1'b1, 1'b1, 1'b0, '0);
      if (acc_prev) begin
        note_failure("fetch accepted while the list was full");
      end
    end
    compare_value("outstanding count", outq.size(), CAPACITY);
    report_test("capacity_stall", e0);

    // Second-oldest freed first, tail must wait for the oldest
    e0     = errors;
    oldest = outq[0];
    second = outq[1];
    take_live(second);
    drive_cycle(1'b1, 1'b1, 1'b1, second);
    repeat (10) begin
      drive_cycle(1'b1, 1'b1, 1'b0, '0);
      if (acc_prev) begin
        note_failure("fetch accepted before the oldest number was freed");
      end
    end
    take_live(oldest);
    drive_cycle(1'b1, 1'b1, 1'b1, oldest);
    a0 = accepts;
    t  = 0;
    while (accepts - a0 < 2) begin
      drive_cycle(1'b1, 1'b1, 1'b0, '0);
      t++;
      if (t > 20) begin
        stall_hit("two fetches after the reclaim");
      end
    end
    repeat (10) drive_cycle(1'b1, 1'b1, 1'b0, '0);
    compare_value("fetches after reclaim", accepts - a0, 2);
    report_test("out_of_order", e0);

    // Downstream stalls in random spans
    e0 = errors;
    random_run(300, 1'b1);
    drain_tags(1'b1);
    report_test("back_pressure", e0);

    e0 = errors;
    random_run(2000, 1'b0);
    drain_tags(1'b1);
    report_test("random_run", e0);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule : tb_seq_fetch

// ==== tb.f ====
hdl/seq_pkg.sv
hdl/fetch_pkg.sv
hdl/seq_num_gen.sv
hdl/fetch_tagger.sv
hdl/seq_fetch_top.sv
dv/tb_seq_fetch.sv

// ==== Bender.yml ====
package:
  name: seq_fetch

sources:
  # Packages first, then the blocks, then the top level
  - hdl/seq_pkg.sv
  - hdl/fetch_pkg.sv
  - hdl/seq_num_gen.sv
  - hdl/fetch_tagger.sv
  - hdl/seq_fetch_top.sv

  # Testbench, top module tb_seq_fetch
  - target: test
    files:
      - dv/tb_seq_fetch.sv
